// File: logic/isa_pkg.sv
package isa_pkg;

    localparam int NUM_REGS = 32;
    localparam int IMM_W    = 16;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regid_t;   // r0 is never tracked
    typedef logic [3:0]  alu_op_t;  // opaque to issue, handed to the ALU as is

    // instruction class from decode
    typedef enum logic [1:0] {
        unit_none   = 2'd0,
        unit_alu    = 2'd1,
        unit_memory = 2'd2,
        unit_mult   = 2'd3
    } unit_t;

    typedef enum logic [1:0] {
        msize_byte = 2'd0,
        msize_half = 2'd1,
        msize_word = 2'd2
    } msize_t;

endpackage

// File: logic/pipe_pkg.sv
package pipe_pkg;

    // functional unit an issued instruction is bound to
    typedef enum logic [2:0] {
        fu_none = 3'd0,
        fu_alu1 = 3'd1,
        fu_alu2 = 3'd2,
        fu_mmu  = 3'd3,
        fu_mlt  = 3'd4
    } fu_t;

    typedef logic [1:0] phase_t;

    // phase counts cycles since issue, entry drops after the last one
    localparam phase_t PHASE_FIRST = 2'd1;
    localparam phase_t PHASE_LAST  = 2'd3;

    typedef struct packed {
        logic   pending;
        fu_t    fu;
        phase_t phase;
    } sb_entry_t;

endpackage

// File: logic/scoreboard.sv
`timescale 1ns/1ps

module scoreboard (
    input  logic                                           clk,
    input  logic                                           resetn,
    input  logic                                           stall,
    input  logic                                           issue_en_0,
    input  logic                                           issue_en_1,
    input  isa_pkg::regid_t                                dest_0,
    input  isa_pkg::regid_t                                dest_1,
    input  pipe_pkg::fu_t                                  fu_0,
    input  pipe_pkg::fu_t                                  fu_1,
    output pipe_pkg::sb_entry_t [isa_pkg::NUM_REGS-1:0]   entries
);

    pipe_pkg::sb_entry_t [isa_pkg::NUM_REGS-1:0] entries_nxt;

    always_comb begin
        entries_nxt = entries;

        // age what is already in flight
        for (int i = 1; i < isa_pkg::NUM_REGS; i++) begin
            if (entries[i].pending) begin
                if (entries[i].phase == pipe_pkg::PHASE_LAST)
                    entries_nxt[i] = '0;
                else
                    entries_nxt[i].phase = entries[i].phase + 2'd1;
            end
        end

        // new writers win over the aging above
        if (issue_en_0 && dest_0 != '0) begin
            entries_nxt[dest_0].pending = 1'b1;
            entries_nxt[dest_0].fu      = fu_0;
            entries_nxt[dest_0].phase   = pipe_pkg::PHASE_FIRST;
        end
        if (issue_en_1 && dest_1 != '0) begin
            entries_nxt[dest_1].pending = 1'b1;
            entries_nxt[dest_1].fu      = fu_1;
            entries_nxt[dest_1].phase   = pipe_pkg::PHASE_FIRST;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            entries <= '0;
        end else if (!stall) begin
            entries <= entries_nxt;
        end
    end

endmodule

// File: logic/pair_check.sv
`timescale 1ns/1ps

module pair_check (
    input  pipe_pkg::sb_entry_t [isa_pkg::NUM_REGS-1:0] entries,
    input  logic                  valid_0,
    input  logic                  valid_1,
    input  isa_pkg::unit_t        unit_0,
    input  isa_pkg::unit_t        unit_1,
    input  isa_pkg::regid_t       rs_0, rt_0, rd_0,
    input  isa_pkg::regid_t       rs_1, rt_1, rd_1,
    input  logic                  read_a_0, read_b_0, write_c_0,
    input  logic                  read_a_1, read_b_1, write_c_1,
    input  logic                  queue_empty,
    input  logic                  stall,
    output logic [1:0]            issue_cnt,
    output logic                  issue_en_0,
    output logic                  issue_en_1,
    output pipe_pkg::fu_t         issue_fu_0,
    output pipe_pkg::fu_t         issue_fu_1
);

    logic ready_0, ready_1;
    logic single_only;

    function automatic logic is_alu(pipe_pkg::fu_t fu);
        return fu == pipe_pkg::fu_alu1 || fu == pipe_pkg::fu_alu2;
    endfunction

    function automatic pipe_pkg::fu_t unit_to_fu(isa_pkg::unit_t unit, pipe_pkg::fu_t alu_tag);
        case (unit)
            isa_pkg::unit_alu:    return alu_tag;
            isa_pkg::unit_memory: return pipe_pkg::fu_mmu;
            isa_pkg::unit_mult:   return pipe_pkg::fu_mlt;
            default:              return pipe_pkg::fu_none;
        endcase
    endfunction

    // slot 0 can take ALU results off the bypass, slot 1 cannot
    assign ready_0 = !(read_a_0 && entries[rs_0].pending && !is_alu(entries[rs_0].fu))
                  && !(read_b_0 && entries[rt_0].pending && !is_alu(entries[rt_0].fu));
    assign ready_1 = !(read_a_1 && entries[rs_1].pending)
                  && !(read_b_1 && entries[rt_1].pending);

    always_comb begin
        single_only = !valid_1 || !ready_1;
        if (write_c_0 && write_c_1 && rd_0 == rd_1)
            single_only = 1'b1;    // WAW inside the pair
        if (write_c_0 && ((read_a_1 && rs_1 == rd_0) || (read_b_1 && rt_1 == rd_0)))
            single_only = 1'b1;    // RAW inside the pair
        if (unit_0 == isa_pkg::unit_memory && unit_1 == isa_pkg::unit_memory)
            single_only = 1'b1;
        if (unit_0 == isa_pkg::unit_mult && unit_1 == isa_pkg::unit_mult)
            single_only = 1'b1;
        // loads and stores only go out of slot 0
        if (unit_1 == isa_pkg::unit_memory)
            single_only = 1'b1;
    end

    always_comb begin
        if (stall || queue_empty || !valid_0 || !ready_0)
            issue_cnt = 2'd0;
        else if (single_only)
            issue_cnt = 2'd1;
        else
            issue_cnt = 2'd2;
    end

    assign issue_en_0 = issue_cnt != 2'd0;
    assign issue_en_1 = issue_cnt == 2'd2;

    assign issue_fu_0 = issue_en_0 ? unit_to_fu(unit_0, pipe_pkg::fu_alu1) : pipe_pkg::fu_none;
    assign issue_fu_1 = issue_en_1 ? unit_to_fu(unit_1, pipe_pkg::fu_alu2) : pipe_pkg::fu_none;

endmodule

// File: logic/bypass_select.sv
`timescale 1ns/1ps

module bypass_select (
    input  isa_pkg::regid_t                              ra,
    input  isa_pkg::word_t                               rd_reg,
    input  pipe_pkg::sb_entry_t [isa_pkg::NUM_REGS-1:0]  entries,
    input  isa_pkg::word_t                               alu1_p1, alu1_p2, alu1_p3,
    input  isa_pkg::word_t                               alu2_p1, alu2_p2, alu2_p3,
    output isa_pkg::word_t                               rd
);

    pipe_pkg::sb_entry_t entry;

    assign entry = entries[ra];

    always_comb begin
        rd = rd_reg;
        if (ra != '0 && entry.pending) begin
            if (entry.fu == pipe_pkg::fu_alu1) begin
                case (entry.phase)
                    2'd1:    rd = alu1_p1;
                    2'd2:    rd = alu1_p2;
                    2'd3:    rd = alu1_p3;
                    default: rd = rd_reg;
                endcase
            end else if (entry.fu == pipe_pkg::fu_alu2) begin
                case (entry.phase)
                    2'd1:    rd = alu2_p1;
                    2'd2:    rd = alu2_p2;
                    2'd3:    rd = alu2_p3;
                    default: rd = rd_reg;
                endcase
            end
        end
    end

endmodule

// File: logic/operand_format.sv
`timescale 1ns/1ps

module operand_format (
    input  pipe_pkg::fu_t                issue_fu_0, issue_fu_1,
    input  isa_pkg::word_t               rd1, rd2, rd3, rd4,
    input  logic [isa_pkg::IMM_W-1:0]    imm_0, imm_1,
    input  logic                         use_imm_0, use_imm_1,
    input  logic                         read_b_0, read_b_1,
    input  logic [4:0]                   shamt_0, shamt_1,
    input  isa_pkg::alu_op_t             alu_op_0, alu_op_1,
    input  logic                         mem_read_0, mem_write_0, mem_unsigned_0,
    input  logic                         mem_read_1, mem_write_1, mem_unsigned_1,
    input  isa_pkg::msize_t              msize_0, msize_1,
    input  logic                         mul_unsigned_0, mul_unsigned_1,
    output logic                         alu1_en, alu2_en,
    output isa_pkg::word_t               alu1_opa, alu1_opb, alu2_opa, alu2_opb,
    output logic [4:0]                   alu1_shamt, alu2_shamt,
    output isa_pkg::alu_op_t             alu1_op, alu2_op,
    output logic                         mmu_en,
    output isa_pkg::word_t               mmu_base, mmu_offset, mmu_data,
    output logic                         mmu_read, mmu_write, mmu_unsigned,
    output isa_pkg::msize_t              mmu_size,
    output logic                         mlt_en,
    output isa_pkg::word_t               mlt_opa, mlt_opb,
    output logic                         mlt_negate
);

    localparam int EXT_W = 32 - isa_pkg::IMM_W;

    logic           mmu_from_1, mlt_from_1;
    isa_pkg::word_t mul_a, mul_b;
    logic           mul_uns;

    function automatic isa_pkg::word_t magnitude(isa_pkg::word_t w);
        return w[31] ? ~w + 32'd1 : w;
    endfunction

    // alu1 only ever gets slot 0, alu2 only slot 1
    assign alu1_en    = issue_fu_0 == pipe_pkg::fu_alu1;
    assign alu1_opa   = alu1_en ? rd1 : '0;
    assign alu1_opb   = !alu1_en ? '0 : use_imm_0 ? {{EXT_W{1'b0}}, imm_0} : rd2;
    assign alu1_shamt = !alu1_en ? '0 : read_b_0 ? rd2[4:0] : shamt_0;  // variable shifts
    assign alu1_op    = alu1_en ? alu_op_0 : '0;

    assign alu2_en    = issue_fu_1 == pipe_pkg::fu_alu2;
    assign alu2_opa   = alu2_en ? rd3 : '0;
    assign alu2_opb   = !alu2_en ? '0 : use_imm_1 ? {{EXT_W{1'b0}}, imm_1} : rd4;
    assign alu2_shamt = !alu2_en ? '0 : read_b_1 ? rd4[4:0] : shamt_1;
    assign alu2_op    = alu2_en ? alu_op_1 : '0;

    assign mmu_from_1 = issue_fu_1 == pipe_pkg::fu_mmu;
    assign mlt_from_1 = issue_fu_1 == pipe_pkg::fu_mlt;
    assign mmu_en     = issue_fu_0 == pipe_pkg::fu_mmu || mmu_from_1;
    assign mlt_en     = issue_fu_0 == pipe_pkg::fu_mlt || mlt_from_1;

    always_comb begin
        mmu_base     = '0;
        mmu_offset   = '0;
        mmu_data     = '0;
        mmu_read     = 1'b0;
        mmu_write    = 1'b0;
        mmu_unsigned = 1'b0;
        mmu_size     = isa_pkg::msize_byte;
        if (mmu_en) begin
            mmu_base     = mmu_from_1 ? rd3 : rd1;
            mmu_offset   = mmu_from_1 ? {{EXT_W{imm_1[isa_pkg::IMM_W-1]}}, imm_1}
                                      : {{EXT_W{imm_0[isa_pkg::IMM_W-1]}}, imm_0};
            mmu_data     = mmu_from_1 ? rd4 : rd2;   // store data
            mmu_read     = mmu_from_1 ? mem_read_1 : mem_read_0;
            mmu_write    = mmu_from_1 ? mem_write_1 : mem_write_0;
            mmu_unsigned = mmu_from_1 ? mem_unsigned_1 : mem_unsigned_0;
            mmu_size     = mmu_from_1 ? msize_1 : msize_0;
        end
    end

    assign mul_a   = mlt_from_1 ? rd3 : rd1;
    assign mul_b   = mlt_from_1 ? rd4 : rd2;
    assign mul_uns = mlt_from_1 ? mul_unsigned_1 : mul_unsigned_0;

    // signed multiply runs on magnitudes, sign is fixed up after
    always_comb begin
        mlt_opa    = '0;
        mlt_opb    = '0;
        mlt_negate = 1'b0;
        if (mlt_en && mul_uns) begin
            mlt_opa = mul_a;
            mlt_opb = mul_b;
        end else if (mlt_en) begin
            mlt_opa    = magnitude(mul_a);
            mlt_opb    = magnitude(mul_b);
            mlt_negate = mul_a[31] ^ mul_b[31];
        end
    end

endmodule

// File: logic/issue_stage.sv
`timescale 1ns/1ps

module issue_stage (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          queue_empty,
    input  logic                          stall,
    input  logic                          valid_0, valid_1,
    input  isa_pkg::unit_t                unit_0, unit_1,
    input  isa_pkg::regid_t               rs_0, rt_0, rd_0,
    input  isa_pkg::regid_t               rs_1, rt_1, rd_1,
    input  logic                          read_a_0, read_b_0, write_c_0,
    input  logic                          read_a_1, read_b_1, write_c_1,
    input  logic                          use_imm_0, use_imm_1,
    input  logic [isa_pkg::IMM_W-1:0]     imm_0, imm_1,
    input  logic [4:0]                    shamt_0, shamt_1,
    input  isa_pkg::alu_op_t              alu_op_0, alu_op_1,
    input  logic                          mem_read_0, mem_write_0, mem_unsigned_0,
    input  logic                          mem_read_1, mem_write_1, mem_unsigned_1,
    input  isa_pkg::msize_t               msize_0, msize_1,
    input  logic                          mul_unsigned_0, mul_unsigned_1,
    input  isa_pkg::word_t                pc_0, pc_1,
    output isa_pkg::regid_t               ra1, ra2, ra3, ra4,
    input  isa_pkg::word_t                rd1_reg, rd2_reg, rd3_reg, rd4_reg,
    input  isa_pkg::word_t                alu1_p1, alu1_p2, alu1_p3,
    input  isa_pkg::word_t                alu2_p1, alu2_p2, alu2_p3,
    output logic [1:0]                    issue_cnt,
    output logic                          issue_en_0, issue_en_1,
    output pipe_pkg::fu_t                 issue_fu_0, issue_fu_1,
    output isa_pkg::regid_t               issue_dest_0, issue_dest_1,
    output isa_pkg::word_t                issue_pc_0, issue_pc_1,
    output logic                          alu1_en, alu2_en,
    output isa_pkg::word_t                alu1_opa, alu1_opb, alu2_opa, alu2_opb,
    output logic [4:0]                    alu1_shamt, alu2_shamt,
    output isa_pkg::alu_op_t              alu1_op, alu2_op,
    output logic                          mmu_en,
    output isa_pkg::word_t                mmu_base, mmu_offset, mmu_data,
    output logic                          mmu_read, mmu_write, mmu_unsigned,
    output isa_pkg::msize_t               mmu_size,
    output logic                          mlt_en,
    output isa_pkg::word_t                mlt_opa, mlt_opb,
    output logic                          mlt_negate
);

    pipe_pkg::sb_entry_t [isa_pkg::NUM_REGS-1:0] entries;
    isa_pkg::word_t rd1, rd2, rd3, rd4;

    assign ra1 = issue_en_0 ? rs_0 : '0;
    assign ra2 = issue_en_0 ? rt_0 : '0;
    assign ra3 = issue_en_1 ? rs_1 : '0;
    assign ra4 = issue_en_1 ? rt_1 : '0;

    assign issue_dest_0 = (issue_en_0 && write_c_0) ? rd_0 : '0;
    assign issue_dest_1 = (issue_en_1 && write_c_1) ? rd_1 : '0;
    assign issue_pc_0   = issue_en_0 ? pc_0 : '0;
    assign issue_pc_1   = issue_en_1 ? pc_1 : '0;

    scoreboard u_scoreboard (
        .clk, .resetn, .stall, .issue_en_0, .issue_en_1,
        .dest_0(issue_dest_0), .dest_1(issue_dest_1),
        .fu_0(issue_fu_0), .fu_1(issue_fu_1), .entries
    );

    pair_check u_pair_check (
        .entries, .valid_0, .valid_1, .unit_0, .unit_1,
        .rs_0, .rt_0, .rd_0, .rs_1, .rt_1, .rd_1,
        .read_a_0, .read_b_0, .write_c_0, .read_a_1, .read_b_1, .write_c_1,
        .queue_empty, .stall,
        .issue_cnt, .issue_en_0, .issue_en_1, .issue_fu_0, .issue_fu_1
    );

    // one bypass mux per register-file read port
    bypass_select u_byp1 (.ra(ra1), .rd_reg(rd1_reg), .entries, .alu1_p1, .alu1_p2,
                          .alu1_p3, .alu2_p1, .alu2_p2, .alu2_p3, .rd(rd1));
    bypass_select u_byp2 (.ra(ra2), .rd_reg(rd2_reg), .entries, .alu1_p1, .alu1_p2,
                          .alu1_p3, .alu2_p1, .alu2_p2, .alu2_p3, .rd(rd2));
    bypass_select u_byp3 (.ra(ra3), .rd_reg(rd3_reg), .entries, .alu1_p1, .alu1_p2,
                          .alu1_p3, .alu2_p1, .alu2_p2, .alu2_p3, .rd(rd3));
    bypass_select u_byp4 (.ra(ra4), .rd_reg(rd4_reg), .entries, .alu1_p1, .alu1_p2,
                          .alu1_p3, .alu2_p1, .alu2_p2, .alu2_p3, .rd(rd4));

    operand_format u_operand_format (
        .issue_fu_0, .issue_fu_1, .rd1, .rd2, .rd3, .rd4,
        .imm_0, .imm_1, .use_imm_0, .use_imm_1, .read_b_0, .read_b_1,
        .shamt_0, .shamt_1, .alu_op_0, .alu_op_1,
        .mem_read_0, .mem_write_0, .mem_unsigned_0,
        .mem_read_1, .mem_write_1, .mem_unsigned_1,
        .msize_0, .msize_1, .mul_unsigned_0, .mul_unsigned_1,
        .alu1_en, .alu2_en, .alu1_opa, .alu1_opb, .alu2_opa, .alu2_opb,
        .alu1_shamt, .alu2_shamt, .alu1_op, .alu2_op,
        .mmu_en, .mmu_base, .mmu_offset, .mmu_data,
        .mmu_read, .mmu_write, .mmu_unsigned, .mmu_size,
        .mlt_en, .mlt_opa, .mlt_opb, .mlt_negate
    );

endmodule

// File: verification/issue_properties.sv
`timescale 1ns/1ps

module issue_properties (
    input logic          clk,
    input logic          resetn,
    input logic          stall,
    input logic [1:0]    issue_cnt,
    input logic          mmu_en,
    input pipe_pkg::fu_t issue_fu_0,
    input pipe_pkg::fu_t issue_fu_1
);

    cnt_in_range: assert property (@(posedge clk) disable iff (!resetn)
        issue_cnt <= 2'd2)
        else $error("issue_cnt above two");

    // single memory unit
    mmu_one_slot: assert property (@(posedge clk) disable iff (!resetn)
        mmu_en |-> ((issue_fu_0 == pipe_pkg::fu_mmu) != (issue_fu_1 == pipe_pkg::fu_mmu)))
        else $error("mmu_en without exactly one slot on the memory unit");

    stall_no_issue: assert property (@(posedge clk) disable iff (!resetn)
        stall |-> issue_cnt == 2'd0)
        else $error("issue while stalled");

endmodule

bind issue_stage issue_properties u_properties (.*);

// File: verification/issue_model.svh
`ifndef ISSUE_MODEL_SVH
`define ISSUE_MODEL_SVH

// expected unit tag for a slot, alu tag depends on the slot
function automatic pipe_pkg::fu_t fu_for(isa_pkg::unit_t u, logic slot1);
    if (u == isa_pkg::unit_alu)
        return slot1 ? pipe_pkg::fu_alu2 : pipe_pkg::fu_alu1;
    if (u == isa_pkg::unit_memory)
        return pipe_pkg::fu_mmu;
    if (u == isa_pkg::unit_mult)
        return pipe_pkg::fu_mlt;
    return pipe_pkg::fu_none;
endfunction

function automatic logic alu_tag(pipe_pkg::fu_t f);
    return (f == pipe_pkg::fu_alu1) || (f == pipe_pkg::fu_alu2);
endfunction

// a read blocks if pending; slot 0 tolerates alu writers
function automatic logic src_blocked(isa_pkg::regid_t r, logic used, logic bypass_ok);
    if (!used || r == 5'd0 || !m_pend[r])
        return 1'b0;
    return !(bypass_ok && alu_tag(m_fu[r]));
endfunction

// read port value as seen after forwarding
function automatic isa_pkg::word_t port_value(isa_pkg::regid_t r, isa_pkg::word_t reg_word);
    if (r == 5'd0 || !m_pend[r])
        return reg_word;
    if (m_fu[r] == pipe_pkg::fu_alu1)
        return (m_phase[r] == 2'd1) ? alu1_p1 : (m_phase[r] == 2'd2) ? alu1_p2 : alu1_p3;
    if (m_fu[r] == pipe_pkg::fu_alu2)
        return (m_phase[r] == 2'd1) ? alu2_p1 : (m_phase[r] == 2'd2) ? alu2_p2 : alu2_p3;
    return reg_word;
endfunction

function automatic isa_pkg::word_t abs_word(isa_pkg::word_t w);
    return w[31] ? (32'd0 - w) : w;
endfunction

function automatic isa_pkg::word_t sext16(logic [15:0] v);
    return {{16{v[15]}}, v};
endfunction

function automatic isa_pkg::word_t zext16(logic [15:0] v);
    return {16'd0, v};
endfunction

`endif

// File: verification/issue_tb.sv
`timescale 1ns/1ps

module issue_tb;

    localparam int NUM_CYCLES = 3000;
    localparam int TIMEOUT_NS = (NUM_CYCLES + 100) * 10;

    logic clk, resetn, queue_empty, stall;
    logic valid_0, valid_1;
    isa_pkg::unit_t unit_0, unit_1;
    isa_pkg::regid_t rs_0, rt_0, rd_0, rs_1, rt_1, rd_1;
    logic read_a_0, read_b_0, write_c_0, read_a_1, read_b_1, write_c_1;
    logic use_imm_0, use_imm_1;
    logic [15:0] imm_0, imm_1;
    logic [4:0] shamt_0, shamt_1;
    isa_pkg::alu_op_t alu_op_0, alu_op_1;
    logic mem_read_0, mem_write_0, mem_unsigned_0;
    logic mem_read_1, mem_write_1, mem_unsigned_1;
    isa_pkg::msize_t msize_0, msize_1;
    logic mul_unsigned_0, mul_unsigned_1;
    isa_pkg::word_t pc_0, pc_1;
    isa_pkg::regid_t ra1, ra2, ra3, ra4;
    isa_pkg::word_t rd1_reg, rd2_reg, rd3_reg, rd4_reg;
    isa_pkg::word_t alu1_p1, alu1_p2, alu1_p3, alu2_p1, alu2_p2, alu2_p3;
    logic [1:0] issue_cnt;
    logic issue_en_0, issue_en_1;
    pipe_pkg::fu_t issue_fu_0, issue_fu_1;
    isa_pkg::regid_t issue_dest_0, issue_dest_1;
    isa_pkg::word_t issue_pc_0, issue_pc_1;
    logic alu1_en, alu2_en;
    isa_pkg::word_t alu1_opa, alu1_opb, alu2_opa, alu2_opb;
    logic [4:0] alu1_shamt, alu2_shamt;
    isa_pkg::alu_op_t alu1_op, alu2_op;
    logic mmu_en, mmu_read, mmu_write, mmu_unsigned;
    isa_pkg::word_t mmu_base, mmu_offset, mmu_data;
    isa_pkg::msize_t mmu_size;
    logic mlt_en, mlt_negate;
    isa_pkg::word_t mlt_opa, mlt_opb;

    // reference scoreboard
    logic           m_pend [isa_pkg::NUM_REGS];
    pipe_pkg::fu_t  m_fu [isa_pkg::NUM_REGS];
    pipe_pkg::phase_t m_phase [isa_pkg::NUM_REGS];

    integer seed = 32'h828ace71;
    logic [1:0] exp_cnt;
    pipe_pkg::fu_t exp_fu0, exp_fu1;
    isa_pkg::regid_t exp_dest0, exp_dest1;

    `include "issue_model.svh"

    issue_stage DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        while ($time < TIMEOUT_NS)
            @(posedge clk);
        $display("Timeout: simulation did not finish within %0d ns", TIMEOUT_NS);
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    end

    task automatic fail_check(input string msg);
        $display("Error at %0t: %s", $time, msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "mismatch");
    endtask

    task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp)
        else fail_check($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    task automatic drive_inputs();
        logic [31:0] r;
        r = rnd();
        stall       = (r[2:0] == 3'd0);   // about one in eight
        queue_empty = (r[6:3] == 4'd0);
        valid_0     = (r[9:7] != 3'd0);
        valid_1     = (r[12:10] != 3'd0);
        unit_0      = isa_pkg::unit_t'(r[14:13]);
        unit_1      = isa_pkg::unit_t'(r[16:15]);
        {read_a_0, read_b_0, write_c_0, read_a_1, read_b_1, write_c_1} = r[22:17];
        {use_imm_0, use_imm_1, mul_unsigned_0, mul_unsigned_1} = r[26:23];
        r = rnd();
        rs_0 = {2'b00, r[2:0]};
        rt_0 = {2'b00, r[5:3]};
        rd_0 = {2'b00, r[8:6]};
        rs_1 = {2'b00, r[11:9]};
        rt_1 = {2'b00, r[14:12]};
        rd_1 = {2'b00, r[17:15]};
        {mem_read_0, mem_write_0, mem_unsigned_0} = r[20:18];
        {mem_read_1, mem_write_1, mem_unsigned_1} = r[23:21];
        msize_0 = isa_pkg::msize_t'(r[25:24] == 2'd3 ? 2'd2 : r[25:24]);
        msize_1 = isa_pkg::msize_t'(r[27:26] == 2'd3 ? 2'd0 : r[27:26]);
        r = rnd();
        imm_0    = r[15:0];
        imm_1    = r[31:16];
        r = rnd();
        shamt_0  = r[4:0];
        shamt_1  = r[9:5];
        alu_op_0 = r[13:10];
        alu_op_1 = r[17:14];
        pc_0 = rnd();
        pc_1 = pc_0 + 32'd4;
        rd1_reg = rnd();
        rd2_reg = rnd();
        rd3_reg = rnd();
        rd4_reg = rnd();
        alu1_p1 = rnd();
        alu1_p2 = rnd();
        alu1_p3 = rnd();
        alu2_p1 = rnd();
        alu2_p2 = rnd();
        alu2_p3 = rnd();
    endtask

    task automatic predict();
        logic ready0, ready1, single;
        ready0 = !src_blocked(rs_0, read_a_0, 1'b1) && !src_blocked(rt_0, read_b_0, 1'b1);
        ready1 = !src_blocked(rs_1, read_a_1, 1'b0) && !src_blocked(rt_1, read_b_1, 1'b0);
        single = !valid_1 || !ready1 || unit_1 == isa_pkg::unit_memory
              || (write_c_0 && write_c_1 && rd_0 == rd_1)
              || (write_c_0 && read_a_1 && rs_1 == rd_0)
              || (write_c_0 && read_b_1 && rt_1 == rd_0)
              || (unit_0 == isa_pkg::unit_mult && unit_1 == isa_pkg::unit_mult);
        if (stall || queue_empty || !valid_0 || !ready0)
            exp_cnt = 2'd0;
        else
            exp_cnt = single ? 2'd1 : 2'd2;
        exp_fu0   = (exp_cnt != 2'd0) ? fu_for(unit_0, 1'b0) : pipe_pkg::fu_none;
        exp_fu1   = (exp_cnt == 2'd2) ? fu_for(unit_1, 1'b1) : pipe_pkg::fu_none;
        exp_dest0 = (exp_cnt != 2'd0 && write_c_0) ? rd_0 : 5'd0;
        exp_dest1 = (exp_cnt == 2'd2 && write_c_1) ? rd_1 : 5'd0;
    endtask

    task automatic check_outputs();
        isa_pkg::word_t a0, b0, a1, b1;
        isa_pkg::regid_t ea1, ea2, ea3, ea4;
        logic m1, u1;
        check_val(issue_cnt, exp_cnt, "issue_cnt");
        check_val(issue_en_0, exp_cnt != 2'd0, "issue_en_0");
        check_val(issue_en_1, exp_cnt == 2'd2, "issue_en_1");
        check_val(issue_fu_0, exp_fu0, "issue_fu_0");
        check_val(issue_fu_1, exp_fu1, "issue_fu_1");
        check_val(issue_dest_0, exp_dest0, "issue_dest_0");
        check_val(issue_dest_1, exp_dest1, "issue_dest_1");
        check_val(issue_pc_0, (exp_cnt != 2'd0) ? pc_0 : 32'd0, "issue_pc_0");
        check_val(issue_pc_1, (exp_cnt == 2'd2) ? pc_1 : 32'd0, "issue_pc_1");
        ea1 = (exp_cnt != 2'd0) ? rs_0 : 5'd0;
        ea2 = (exp_cnt != 2'd0) ? rt_0 : 5'd0;
        ea3 = (exp_cnt == 2'd2) ? rs_1 : 5'd0;
        ea4 = (exp_cnt == 2'd2) ? rt_1 : 5'd0;
        check_val(ra1, ea1, "ra1");
        check_val(ra2, ea2, "ra2");
        check_val(ra3, ea3, "ra3");
        check_val(ra4, ea4, "ra4");
        a0 = port_value(ea1, rd1_reg);
        b0 = port_value(ea2, rd2_reg);
        a1 = port_value(ea3, rd3_reg);
        b1 = port_value(ea4, rd4_reg);
        check_val(alu1_en, exp_fu0 == pipe_pkg::fu_alu1, "alu1_en");
        check_val(alu2_en, exp_fu1 == pipe_pkg::fu_alu2, "alu2_en");
        check_val(mmu_en, exp_fu0 == pipe_pkg::fu_mmu || exp_fu1 == pipe_pkg::fu_mmu, "mmu_en");
        check_val(mlt_en, exp_fu0 == pipe_pkg::fu_mlt || exp_fu1 == pipe_pkg::fu_mlt, "mlt_en");
        if (alu1_en) begin
            check_val(alu1_opa, a0, "alu1_opa");
            check_val(alu1_opb, use_imm_0 ? zext16(imm_0) : b0, "alu1_opb");
            check_val(alu1_shamt, read_b_0 ? b0[4:0] : shamt_0, "alu1_shamt");
            check_val(alu1_op, alu_op_0, "alu1_op");
        end
        if (alu2_en) begin
            check_val(alu2_opa, a1, "alu2_opa");
            check_val(alu2_opb, use_imm_1 ? zext16(imm_1) : b1, "alu2_opb");
            check_val(alu2_shamt, read_b_1 ? b1[4:0] : shamt_1, "alu2_shamt");
            check_val(alu2_op, alu_op_1, "alu2_op");
        end
        if (mmu_en) begin
            m1 = exp_fu1 == pipe_pkg::fu_mmu;
            check_val(mmu_base, m1 ? a1 : a0, "mmu_base");
            check_val(mmu_offset, sext16(m1 ? imm_1 : imm_0), "mmu_offset");
            check_val(mmu_data, m1 ? b1 : b0, "mmu_data");
            check_val(mmu_read, m1 ? mem_read_1 : mem_read_0, "mmu_read");
            check_val(mmu_write, m1 ? mem_write_1 : mem_write_0, "mmu_write");
            check_val(mmu_unsigned, m1 ? mem_unsigned_1 : mem_unsigned_0, "mmu_unsigned");
            check_val(mmu_size, m1 ? msize_1 : msize_0, "mmu_size");
        end
        if (mlt_en) begin
            m1 = exp_fu1 == pipe_pkg::fu_mlt;
            u1 = m1 ? mul_unsigned_1 : mul_unsigned_0;
            if (m1) begin
                a0 = a1;
                b0 = b1;
            end
            check_val(mlt_opa, u1 ? a0 : abs_word(a0), "mlt_opa");
            check_val(mlt_opb, u1 ? b0 : abs_word(b0), "mlt_opb");
            check_val(mlt_negate, u1 ? 1'b0 : a0[31] ^ b0[31], "mlt_negate");
        end
    endtask

    // mirrors the edge update of the pending table
    task automatic advance_model();
        for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
            if (m_pend[i] && m_phase[i] == pipe_pkg::PHASE_LAST) begin
                m_pend[i] = 1'b0;
                m_fu[i]   = pipe_pkg::fu_none;
                m_phase[i] = 2'd0;
            end else if (m_pend[i]) begin
                m_phase[i] = m_phase[i] + 2'd1;
            end
        end
        if (exp_dest0 != 5'd0) begin
            m_pend[exp_dest0]  = 1'b1;
            m_fu[exp_dest0]    = exp_fu0;
            m_phase[exp_dest0] = pipe_pkg::PHASE_FIRST;
        end
        if (exp_dest1 != 5'd0) begin
            m_pend[exp_dest1]  = 1'b1;
            m_fu[exp_dest1]    = exp_fu1;
            m_phase[exp_dest1] = pipe_pkg::PHASE_FIRST;
        end
    endtask

    initial begin
        for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
            m_pend[i]  = 1'b0;
            m_fu[i]    = pipe_pkg::fu_none;
            m_phase[i] = 2'd0;
        end
        resetn = 1'b0;
        drive_inputs();
        valid_0 = 1'b0;   // idle slots through reset
        valid_1 = 1'b0;
        stall   = 1'b0;
        repeat (4) @(posedge clk);
        #1 resetn = 1'b1;
        @(negedge clk);
        predict();
        check_outputs();   // nothing valid right after reset
        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            @(posedge clk);
            if (!stall)
                advance_model();
            #1 drive_inputs();
            @(negedge clk);
            predict();
            check_outputs();
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: src.f
+incdir+verification
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/scoreboard.sv
logic/pair_check.sv
logic/bypass_select.sv
logic/operand_format.sv
logic/issue_stage.sv
verification/issue_properties.sv
verification/issue_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= issue_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
